// File: common/render_pkg.sv
package render_pkg;

    // ==============================
    // sizes
    // ==============================
    localparam int MAX_MODELS      = 8;
    localparam int MODEL_ID_W      = 3;
    localparam int MAX_INSTANCES   = 16;
    localparam int INST_ADDR_W     = 4;
    localparam int MAX_TRIANGLES   = 64;
    localparam int TRI_ADDR_W      = 6;
    localparam int TRI_CNT_W       = 7;
    localparam int FRAC_BITS       = 8;
    localparam int INST_FIFO_DEPTH = 2;
    localparam int OUT_FIFO_DEPTH  = 4;

    // ==============================
    // geometry types
    // ==============================
    // q8.8 signed fixed point.
    typedef logic signed [15:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // m[row][col], col 0..2 multiplies x, y, z.
    typedef struct packed {
        coord_t [2:0][2:0] m;
        coord_t [2:0]      t;
    } transform_t;

    typedef struct packed {
        logic [MODEL_ID_W-1:0] model_id;
        transform_t            xf;
    } model_instance_t;

    // count must be nonzero.
    typedef struct packed {
        logic [TRI_ADDR_W-1:0] base;
        logic [TRI_CNT_W-1:0]  count;
    } model_entry_t;

    typedef struct packed {
        triangle_t triangle;
        logic      triangle_last;
        logic      model_last;
    } tri_out_t;

    // ==============================
    // transform rule
    // ==============================
    function automatic coord_t vtx_coord(vertex_t v, int i);
        case (i)
            0:       return v.x;
            1:       return v.y;
            default: return v.z;
        endcase
    endfunction

    function automatic vertex_t tri_vertex(triangle_t t, int i);
        case (i)
            0:       return t.v0;
            1:       return t.v1;
            default: return t.v2;
        endcase
    endfunction

    // sum in 34 bits, shift back to q8.8 and wrap to 16 bits.
    function automatic coord_t xf_finish(logic signed [31:0] p0, p1, p2, coord_t t);
        logic signed [33:0] acc;
        acc = p0 + p1 + p2 + (34'(t) <<< FRAC_BITS);
        return coord_t'(acc >>> FRAC_BITS);
    endfunction

    function automatic vertex_t xf_apply(transform_t xf, vertex_t v);
        logic signed [31:0] p [3];
        coord_t             c [3];
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 3; k++) begin
                p[k] = xf.m[r][k] * vtx_coord(v, k);
            end
            c[r] = xf_finish(p[0], p[1], p[2], xf.t[r]);
        end
        return '{x: c[0], y: c[1], z: c[2]};
    endfunction

endpackage

// File: geometry_front.f
common/render_pkg.sv
hw/stream_fifo.sv
hw/scene_buffer.sv
hw/model_buffer.sv
hw/vertex_transform.sv
hw/scene_reader/scene_reader.sv
hw/geometry_front.sv
test/geometry_front_tb.sv

// File: hw/geometry_front.sv
`timescale 1ns/10ps

module geometry_front import render_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   scene_wr,
    input  logic [INST_ADDR_W-1:0] scene_wr_addr,
    input  model_instance_t        scene_wr_data,
    input  logic                   model_wr,
    input  logic [MODEL_ID_W-1:0]  model_wr_addr,
    input  model_entry_t           model_wr_data,
    input  logic                   tri_wr,
    input  logic [TRI_ADDR_W-1:0]  tri_wr_addr,
    input  triangle_t              tri_wr_data,
    input  logic                   start,
    input  logic [INST_ADDR_W:0]   inst_count,
    output logic                   out_valid,
    input  logic                   out_ready,
    output tri_out_t               out_data,
    output logic                   done
);

    typedef struct packed {
        logic            last;
        model_instance_t inst;
    } inst_beat_t;

    logic            scene_busy, start_ok, rd_done;
    logic            sb_valid, sb_ready, sb_last;
    model_instance_t sb_data;
    inst_beat_t      sb_beat, if_beat;
    logic            if_valid, if_ready;
    logic            req_valid, req_ready;
    logic [MODEL_ID_W-1:0] req_model;
    logic [TRI_CNT_W-1:0]  req_index;
    logic            tri_valid, tri_ready, tri_last;
    triangle_t       tri_data;
    logic            pair_valid, pair_ready, pair_tri_last, pair_model_last;
    triangle_t       pair_tri;
    transform_t      pair_xf;
    logic            vt_valid, vt_ready;
    tri_out_t        vt_data;

    // a scene runs from an accepted start until the reader finishes.
    assign start_ok = start && !scene_busy;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            scene_busy <= 1'b0;
        end else if (start_ok) begin
            scene_busy <= 1'b1;
        end else if (rd_done) begin
            scene_busy <= 1'b0;
        end
    end

    assign sb_beat = '{last: sb_last, inst: sb_data};
    assign done    = vt_valid && vt_ready && vt_data.triangle_last && vt_data.model_last;

    scene_buffer i_scene_buffer (
        .clk(clk), .rstn(rstn), .scene_wr(scene_wr), .scene_wr_addr(scene_wr_addr),
        .scene_wr_data(scene_wr_data), .start(start_ok), .inst_count(inst_count),
        .inst_valid(sb_valid), .inst_ready(sb_ready), .inst_data(sb_data),
        .inst_last(sb_last)
    );

    stream_fifo #(.payload_t(inst_beat_t), .DEPTH(INST_FIFO_DEPTH)) i_inst_fifo (
        .clk(clk), .rstn(rstn), .in_valid(sb_valid), .in_ready(sb_ready),
        .in_data(sb_beat), .out_valid(if_valid), .out_ready(if_ready), .out_data(if_beat)
    );

    scene_reader i_scene_reader (
        .clk(clk), .rstn(rstn), .start(start_ok),
        .inst_valid(if_valid), .inst_last(if_beat.last), .inst_data(if_beat.inst),
        .inst_ready(if_ready), .req_valid(req_valid), .req_model(req_model),
        .req_index(req_index), .req_ready(req_ready), .tri_valid(tri_valid),
        .tri_last(tri_last), .tri_data(tri_data), .tri_ready(tri_ready),
        .pair_valid(pair_valid), .pair_tri(pair_tri), .pair_xf(pair_xf),
        .pair_tri_last(pair_tri_last), .pair_model_last(pair_model_last),
        .pair_ready(pair_ready), .done(rd_done)
    );

    model_buffer i_model_buffer (
        .clk(clk), .rstn(rstn), .model_wr(model_wr), .model_wr_addr(model_wr_addr),
        .model_wr_data(model_wr_data), .tri_wr(tri_wr), .tri_wr_addr(tri_wr_addr),
        .tri_wr_data(tri_wr_data), .req_valid(req_valid), .req_ready(req_ready),
        .req_model(req_model), .req_index(req_index), .tri_valid(tri_valid),
        .tri_ready(tri_ready), .tri_data(tri_data), .tri_last(tri_last)
    );

    vertex_transform i_vertex_transform (
        .clk(clk), .rstn(rstn), .in_valid(pair_valid), .in_ready(pair_ready),
        .in_tri(pair_tri), .in_xf(pair_xf), .in_tri_last(pair_tri_last),
        .in_model_last(pair_model_last), .out_valid(vt_valid), .out_ready(vt_ready),
        .out_data(vt_data)
    );

    stream_fifo #(.payload_t(tri_out_t), .DEPTH(OUT_FIFO_DEPTH)) i_out_fifo (
        .clk(clk), .rstn(rstn), .in_valid(vt_valid), .in_ready(vt_ready),
        .in_data(vt_data), .out_valid(out_valid), .out_ready(out_ready),
        .out_data(out_data)
    );

endmodule

// File: hw/model_buffer.sv
`timescale 1ns/10ps

module model_buffer import render_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  model_wr,
    input  logic [MODEL_ID_W-1:0] model_wr_addr,
    input  model_entry_t          model_wr_data,
    input  logic                  tri_wr,
    input  logic [TRI_ADDR_W-1:0] tri_wr_addr,
    input  triangle_t             tri_wr_data,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic [MODEL_ID_W-1:0] req_model,
    input  logic [TRI_CNT_W-1:0]  req_index,
    output logic                  tri_valid,
    input  logic                  tri_ready,
    output triangle_t             tri_data,
    output logic                  tri_last
);

    model_entry_t          model_mem [MAX_MODELS];
    triangle_t             tri_mem [MAX_TRIANGLES];
    model_entry_t          entry;
    logic [TRI_ADDR_W-1:0] tri_addr;
    logic                  req_fire;

    assign entry     = model_mem[req_model];
    assign tri_addr  = entry.base + req_index[TRI_ADDR_W-1:0];

    // one slot, free when empty or being drained.
    assign req_ready = !tri_valid || tri_ready;
    assign req_fire  = req_valid && req_ready;

    // ==============================
    // storage and output register
    // ==============================
    always_ff @(posedge clk) begin
        if (model_wr) begin
            model_mem[model_wr_addr] <= model_wr_data;
        end
        if (tri_wr) begin
            tri_mem[tri_wr_addr] <= tri_wr_data;
        end
        if (req_fire) begin
            tri_data <= tri_mem[tri_addr];
            tri_last <= (req_index == entry.count - 1'b1);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tri_valid <= 1'b0;
        end else if (req_fire) begin
            tri_valid <= 1'b1;
        end else if (tri_ready) begin
            tri_valid <= 1'b0;
        end
    end

    // reader must stop at the model's last triangle.
    a_index_in_range: assert property (@(posedge clk) disable iff (!rstn)
        req_valid |-> req_index < entry.count);

endmodule

// File: hw/scene_buffer.sv
`timescale 1ns/10ps

module scene_buffer import render_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   scene_wr,
    input  logic [INST_ADDR_W-1:0] scene_wr_addr,
    input  model_instance_t        scene_wr_data,
    input  logic                   start,
    input  logic [INST_ADDR_W:0]   inst_count,
    output logic                   inst_valid,
    input  logic                   inst_ready,
    output model_instance_t        inst_data,
    output logic                   inst_last
);

    model_instance_t        mem [MAX_INSTANCES];
    logic [INST_ADDR_W-1:0] rd_ptr;
    logic [INST_ADDR_W:0]   count;
    logic                   armed;

    assign inst_valid = armed;
    assign inst_data  = mem[rd_ptr];
    assign inst_last  = ({1'b0, rd_ptr} == count - 1'b1);

    always_ff @(posedge clk) begin
        if (scene_wr) begin
            mem[scene_wr_addr] <= scene_wr_data;
        end
    end

    // ==============================
    // read pointer
    // ==============================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            armed  <= 1'b0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (!armed) begin
            if (start) begin
                armed  <= 1'b1;
                rd_ptr <= '0;
                count  <= inst_count;
            end
        end else if (inst_valid && inst_ready) begin
            if (inst_last) begin
                armed <= 1'b0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    a_count_nonzero: assert property (@(posedge clk) disable iff (!rstn)
        start && !armed |-> inst_count != '0);

endmodule

// File: hw/scene_reader/scene_reader.sv
`timescale 1ns/10ps

module scene_reader import render_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  start,

    input  logic                  inst_valid,
    input  logic                  inst_last,
    input  model_instance_t       inst_data,
    output logic                  inst_ready,

    output logic                  req_valid,
    output logic [MODEL_ID_W-1:0] req_model,
    output logic [TRI_CNT_W-1:0]  req_index,
    input  logic                  req_ready,

    input  logic                  tri_valid,
    input  logic                  tri_last,
    input  triangle_t             tri_data,
    output logic                  tri_ready,

    output logic                  pair_valid,
    output triangle_t             pair_tri,
    output transform_t            pair_xf,
    output logic                  pair_tri_last,
    output logic                  pair_model_last,
    input  logic                  pair_ready,

    output logic                  done
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        STREAM
    } state_t;

    state_t          state;
    model_instance_t cur_inst;
    logic            cur_last;
    logic [1:0]      outstanding;
    logic            req_fire;
    logic            tri_fire;

    assign req_fire = req_valid && req_ready;
    assign tri_fire = tri_valid && tri_ready;

    assign inst_ready = (state == FETCH);

    // next request only once the previous triangle leaves and was not the last.
    assign req_valid = (state == STREAM) &&
                       (outstanding == 2'd0 || (tri_fire && !tri_last));
    assign req_model = cur_inst.model_id;

    // triangles pass straight through, tagged with the instance transform.
    assign pair_valid      = tri_valid;
    assign pair_tri        = tri_data;
    assign pair_xf         = cur_inst.xf;
    assign pair_tri_last   = tri_last;
    assign pair_model_last = cur_last;
    assign tri_ready       = pair_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= IDLE;
            outstanding <= 2'd0;
            req_index   <= '0;
            done        <= 1'b0;
        end else begin
            done        <= 1'b0;
            outstanding <= outstanding + 2'(req_fire) - 2'(tri_fire);
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (inst_valid) begin
                        req_index <= '0;
                        state     <= STREAM;
                    end
                end
                STREAM: begin
                    if (req_fire) begin
                        req_index <= req_index + 1'b1;
                    end
                    if (tri_fire && tri_last) begin
                        if (cur_last) begin
                            state <= IDLE;
                            done  <= 1'b1;
                        end else begin
                            state <= FETCH;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && inst_ready) begin
            cur_inst <= inst_data;
            cur_last <= inst_last;
        end
    end

    // nothing left in flight once a model is finished.
    a_no_req_idle: assert property (@(posedge clk) disable iff (!rstn)
        state != STREAM |-> outstanding == 2'd0 && !tri_valid);

endmodule

// File: hw/stream_fifo.sv
`timescale 1ns/10ps

module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t                 mem [DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                     push;
    logic                     pop;

    assign in_ready  = (count != DEPTH);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + push - pop;
        end
    end

    // a write never lands on a slot that still holds unread data.
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        push && count != '0 |-> wr_ptr != rd_ptr);

endmodule

// File: hw/vertex_transform.sv
`timescale 1ns/10ps

module vertex_transform import render_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       in_valid,
    output logic       in_ready,
    input  triangle_t  in_tri,
    input  transform_t in_xf,
    input  logic       in_tri_last,
    input  logic       in_model_last,
    output logic       out_valid,
    input  logic       out_ready,
    output tri_out_t   out_data
);

    logic               advance;
    logic               s1_valid;
    logic signed [31:0] s1_prod [3][3][3];
    coord_t [2:0]       s1_t;
    logic               s1_tri_last;
    logic               s1_model_last;
    coord_t             res [3][3];

    // whole pipe moves or holds as one.
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    // ==============================
    // stage 1, products
    // ==============================
    always_ff @(posedge clk) begin
        if (advance) begin
            for (int v = 0; v < 3; v++) begin
                for (int r = 0; r < 3; r++) begin
                    for (int k = 0; k < 3; k++) begin
                        s1_prod[v][r][k] <= in_xf.m[r][k] * vtx_coord(tri_vertex(in_tri, v), k);
                    end
                end
            end
            s1_t          <= in_xf.t;
            s1_tri_last   <= in_tri_last;
            s1_model_last <= in_model_last;
        end
    end

    // ==============================
    // stage 2, sums
    // ==============================
    always_comb begin
        for (int v = 0; v < 3; v++) begin
            for (int r = 0; r < 3; r++) begin
                res[v][r] = xf_finish(s1_prod[v][r][0], s1_prod[v][r][1],
                                      s1_prod[v][r][2], s1_t[r]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_data.triangle.v0   <= '{res[0][0], res[0][1], res[0][2]};
            out_data.triangle.v1   <= '{res[1][0], res[1][1], res[1][2]};
            out_data.triangle.v2   <= '{res[2][0], res[2][1], res[2][2]};
            out_data.triangle_last <= s1_tri_last;
            out_data.model_last    <= s1_model_last;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the geometry front end testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module geometry_front_tb -f geometry_front.f \
    || { echo "verilator build error"; exit 1; }

out=$(./obj_dir/Vgeometry_front_tb)
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1

// File: test/geometry_front_tb.sv
`timescale 1ns/10ps

module geometry_front_tb import render_pkg::*; ();

    logic                   clk;
    logic                   rstn;
    logic                   scene_wr;
    logic [INST_ADDR_W-1:0] scene_wr_addr;
    model_instance_t        scene_wr_data;
    logic                   model_wr;
    logic [MODEL_ID_W-1:0]  model_wr_addr;
    model_entry_t           model_wr_data;
    logic                   tri_wr;
    logic [TRI_ADDR_W-1:0]  tri_wr_addr;
    triangle_t              tri_wr_data;
    logic                   start;
    logic [INST_ADDR_W:0]   inst_count;
    logic                   out_valid;
    logic                   out_ready = 1'b1;
    tri_out_t               out_data;
    logic                   done;

    int         seed = 32'h5c30;
    string      test_name = "reset";
    bit         rnd_ready = 1'b0;
    bit         hung = 1'b0;
    int         err_cnt = 0;
    int         chk_cnt = 0;
    int         done_cnt = 0;
    int         done_base = 0;
    int         exp_left = 0;
    int         n_tests = 0;
    int         n_fail = 0;
    tri_out_t   exp_q[$];
    tri_out_t   exp_head = '0;
    int         mdl_base[MAX_MODELS];
    int         mdl_cnt[MAX_MODELS];
    triangle_t  tri_store[MAX_TRIANGLES];
    int         inst_model[MAX_INSTANCES];
    transform_t inst_xf[MAX_INSTANCES];

    geometry_front i_dut (
        .clk(clk), .rstn(rstn), .scene_wr(scene_wr), .scene_wr_addr(scene_wr_addr),
        .scene_wr_data(scene_wr_data), .model_wr(model_wr), .model_wr_addr(model_wr_addr),
        .model_wr_data(model_wr_data), .tri_wr(tri_wr), .tri_wr_addr(tri_wr_addr),
        .tri_wr_data(tri_wr_data), .start(start), .inst_count(inst_count),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        out_ready <= rnd_ready ? 1'($random(seed)) : 1'b1;
    end

    // ==============================
    // reference model
    // ==============================
    function automatic coord_t ref_row(coord_t a, coord_t b, coord_t c, coord_t t,
                                       coord_t x, coord_t y, coord_t z);
        logic signed [33:0] acc;
        acc = 34'(a) * 34'(x) + 34'(b) * 34'(y) + 34'(c) * 34'(z) + (34'(t) <<< FRAC_BITS);
        return coord_t'(acc >>> FRAC_BITS);
    endfunction

    function automatic vertex_t ref_vertex(transform_t xf, vertex_t v);
        vertex_t o;
        o.x = ref_row(xf.m[0][0], xf.m[0][1], xf.m[0][2], xf.t[0], v.x, v.y, v.z);
        o.y = ref_row(xf.m[1][0], xf.m[1][1], xf.m[1][2], xf.t[1], v.x, v.y, v.z);
        o.z = ref_row(xf.m[2][0], xf.m[2][1], xf.m[2][2], xf.t[2], v.x, v.y, v.z);
        return o;
    endfunction

    function automatic triangle_t ref_tri(transform_t xf, triangle_t t);
        return '{v0: ref_vertex(xf, t.v0), v1: ref_vertex(xf, t.v1), v2: ref_vertex(xf, t.v2)};
    endfunction

    function automatic coord_t rand_coord();
        return coord_t'($random(seed));
    endfunction

    function automatic triangle_t rand_tri();
        triangle_t t;
        t = '0;
        for (int i = 0; i < 9; i++) begin
            t = {t[127:0], rand_coord()};
        end
        return t;
    endfunction

    function automatic transform_t rand_xf();
        transform_t xf;
        xf = '0;
        for (int i = 0; i < 12; i++) begin
            xf = {xf[175:0], rand_coord()};
        end
        return xf;
    endfunction

    // ==============================
    // output monitor and checks
    // ==============================
    always @(posedge clk) begin
        if (rstn && out_valid && out_ready) begin
            chk_cnt <= chk_cnt + 1;
            if (exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
        end
        if (exp_q.size() != 0) begin
            exp_head <= exp_q[0];
        end else begin
            exp_head <= '0;
        end
        exp_left <= exp_q.size();
        if (rstn && done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    a_out_match: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && out_ready |-> out_data == exp_head)
        else begin
            err_cnt++;
            $display("FAIL %s: expected %h, actual %h", test_name,
                     $sampled(exp_head), $sampled(out_data));
        end

    a_flags: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && out_ready |-> out_data.triangle_last == exp_head.triangle_last &&
                                   out_data.model_last == exp_head.model_last)
        else begin
            err_cnt++;
            $display("FAIL %s flags: expected %b%b, actual %b%b", test_name,
                     $sampled(exp_head.triangle_last), $sampled(exp_head.model_last),
                     $sampled(out_data.triangle_last), $sampled(out_data.model_last));
        end

    a_no_extra: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && out_ready |-> exp_left != 0)
        else begin
            err_cnt++;
            $display("%s: output triangle arrived when none was expected", test_name);
        end

    // done comes while the final triangle is still on its way out.
    a_done_pending: assert property (@(posedge clk) disable iff (!rstn)
        done |-> exp_left != 0)
        else begin
            err_cnt++;
            $display("%s: done pulsed with no triangle left to deliver", test_name);
        end

    a_done_once: assert property (@(posedge clk) disable iff (!rstn)
        done |-> done_cnt == done_base)
        else begin
            err_cnt++;
            $display("%s: done pulsed more than once in one scene", test_name);
        end

    // ==============================
    // host side
    // ==============================
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic write_model(input int id, input int base, input int cnt);
        triangle_t t;
        model_wr      = 1'b1;
        model_wr_addr = MODEL_ID_W'(id);
        model_wr_data = '{base: TRI_ADDR_W'(base), count: TRI_CNT_W'(cnt)};
        tick();
        model_wr     = 1'b0;
        mdl_base[id] = base;
        mdl_cnt[id]  = cnt;
        for (int j = 0; j < cnt; j++) begin
            t                = rand_tri();
            tri_store[base + j] = t;
            tri_wr           = 1'b1;
            tri_wr_addr      = TRI_ADDR_W'(base + j);
            tri_wr_data      = t;
            tick();
        end
        tri_wr = 1'b0;
    endtask

    task automatic write_instance(input int addr, input int model, input transform_t xf);
        scene_wr      = 1'b1;
        scene_wr_addr = INST_ADDR_W'(addr);
        scene_wr_data = '{model_id: MODEL_ID_W'(model), xf: xf};
        tick();
        scene_wr         = 1'b0;
        inst_model[addr] = model;
        inst_xf[addr]    = xf;
    endtask

    // instance order, then triangle order.
    task automatic expect_scene(input int n);
        int       cnt;
        int       base;
        tri_out_t e;
        for (int i = 0; i < n; i++) begin
            cnt  = mdl_cnt[inst_model[i]];
            base = mdl_base[inst_model[i]];
            for (int j = 0; j < cnt; j++) begin
                e.triangle      = ref_tri(inst_xf[i], tri_store[base + j]);
                e.triangle_last = (j == cnt - 1);
                e.model_last    = (i == n - 1);
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!hung && done_cnt == done_base && n < limit) begin
            tick();
            n++;
        end
        if (!hung && done_cnt == done_base) begin
            hung = 1'b1;
            $display("%s: timed out waiting for done", test_name);
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (!hung && exp_left != 0 && n < limit) begin
            tick();
            n++;
        end
        if (!hung && exp_left != 0) begin
            hung = 1'b1;
            $display("%s: timed out with %0d triangles missing", test_name, exp_left);
        end
    endtask

    task automatic run_scene(input string name, input int n, input bit bp, input bit restart);
        int err_base;
        int chk_base;
        int n_done;
        test_name = name;
        err_base  = err_cnt;
        chk_base  = chk_cnt;
        done_base = done_cnt;
        rnd_ready = bp;
        if (!hung) begin
            start      = 1'b1;
            inst_count = (INST_ADDR_W + 1)'(n);
            tick();
            start = 1'b0;
            if (restart) begin
                tick();
                tick();
                start      = 1'b1;
                inst_count = 1;
                tick();
                start = 1'b0;
            end
            wait_done(2000);
            wait_drain(2000);
            // quiet window catches duplicates.
            repeat (10) tick();
        end
        rnd_ready = 1'b0;
        n_done    = done_cnt - done_base;
        a_done_count: assert (hung || n_done == 1)
            else begin
                err_cnt++;
                $display("FAIL %s done pulses: expected 1, actual %0d", name, n_done);
            end
        n_tests++;
        if (hung || err_cnt != err_base) begin
            n_fail++;
        end
        $display("%s: %0d triangles, %0d errors", name, chk_cnt - chk_base,
                 err_cnt - err_base);
    endtask

    // ==============================
    // scenes
    // ==============================
    initial begin
        transform_t xf;
        tri_out_t   e;
        rstn          = 1'b0;
        scene_wr      = 1'b0;
        scene_wr_addr = '0;
        scene_wr_data = '0;
        model_wr      = 1'b0;
        model_wr_addr = '0;
        model_wr_data = '0;
        tri_wr        = 1'b0;
        tri_wr_addr   = '0;
        tri_wr_data   = '0;
        start         = 1'b0;
        inst_count    = '0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        tick();

        write_model(0, 0, 1);
        write_model(1, 4, 3);
        write_model(2, 10, 5);
        write_model(3, 20, 2);

        // identity leaves the triangle untouched.
        xf         = '0;
        xf.m[0][0] = 16'sh0100;
        xf.m[1][1] = 16'sh0100;
        xf.m[2][2] = 16'sh0100;
        write_instance(0, 0, xf);
        e = '{triangle: tri_store[0], triangle_last: 1'b1, model_last: 1'b1};
        exp_q.push_back(e);
        run_scene("identity", 1, 1'b0, 1'b0);

        for (int i = 0; i < 3; i++) begin
            write_instance(i, i + 1, rand_xf());
        end
        expect_scene(3);
        run_scene("random_xf", 3, 1'b0, 1'b0);
        expect_scene(3);
        run_scene("backpressure", 3, 1'b1, 1'b0);
        expect_scene(3);
        run_scene("restart", 3, 1'b0, 1'b1);

        write_instance(0, 2, rand_xf());
        write_instance(1, 2, rand_xf());
        expect_scene(2);
        run_scene("shared_model", 2, 1'b0, 1'b0);

        write_instance(0, 3, rand_xf());
        write_instance(1, 0, rand_xf());
        write_instance(2, 2, rand_xf());
        write_instance(3, 1, rand_xf());
        expect_scene(4);
        run_scene("last_flags", 4, 1'b1, 1'b0);

        $display("%0d scenes run, %0d failing, %0d errors", n_tests, n_fail, err_cnt);
        if (err_cnt == 0 && !hung) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
